// File: design/pe_pkg.sv
package pe_pkg;

  typedef logic [31:0] word_t;

  // ========================================
  // address map
  // ========================================
  localparam word_t BOOT_BASE = 32'h0000_0000;
  localparam word_t BOOT_LAST = 32'h1fff_ffff;
  localparam word_t RAM_BASE  = 32'h4000_0000;
  localparam word_t RAM_LAST  = 32'h5fff_ffff;
  localparam word_t DMA_BASE  = 32'h2000_0000;
  localparam word_t DMA_LAST  = 32'h2000_0024;

  // dma register offsets from DMA_BASE
  localparam int REG_OFF_W = 6;
  localparam logic [REG_OFF_W-1:0] REG_NODE_ID   = 6'h00;
  localparam logic [REG_OFF_W-1:0] REG_SEND_DEST = 6'h04;
  localparam logic [REG_OFF_W-1:0] REG_SEND_ADDR = 6'h08;
  localparam logic [REG_OFF_W-1:0] REG_SEND_SIZE = 6'h0c;
  localparam logic [REG_OFF_W-1:0] REG_SEND_CMD  = 6'h10;
  localparam logic [REG_OFF_W-1:0] REG_STATUS    = 6'h14;
  localparam logic [REG_OFF_W-1:0] REG_RECV_ADDR = 6'h18;
  localparam logic [REG_OFF_W-1:0] REG_RECV_PTR  = 6'h1c;
  localparam logic [REG_OFF_W-1:0] REG_RECV_SIZE = 6'h20;
  localparam logic [REG_OFF_W-1:0] REG_RECV_CMD  = 6'h24;

  // ========================================
  // flits
  // ========================================
  typedef struct packed {
    logic [7:0]  dest_x;
    logic [7:0]  dest_y;
    logic [15:0] size;
  } flit_header_t;

  // first flit of a packet is a header, the rest are payload
  typedef union packed {
    flit_header_t header;
    word_t        payload;
  } flit_t;

  // ========================================
  // dma register block <-> engine
  // ========================================
  typedef struct packed {
    logic [15:0] send_dest;
    word_t       send_addr;
    logic [15:0] send_size;
    logic        send_start;
    word_t       recv_addr;
    logic        recv_arm;
  } dma_cfg_t;

  typedef struct packed {
    logic        send_busy;
    logic        recv_busy;
    logic        recv_done;
    word_t       recv_ptr;
    logic [15:0] recv_size;
  } dma_stat_t;

  // the core sees the register window big-endian
  function automatic word_t swap_bytes(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

// File: design/pe_bus_decoder.sv
`timescale 1ns/1ps

module pe_bus_decoder #(
  parameter int unsigned RAM_WORDS  = 1024,
  parameter int unsigned BOOT_WORDS = 16
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  pe_pkg::word_t                   wb_adr_i,
  input  pe_pkg::word_t                   wb_dat_i,
  output pe_pkg::word_t                   wb_dat_o,
  output logic                            wb_ack_o,
  output logic                            wb_err_o,
  output logic                            ram_en_o,
  output logic                            ram_we_o,
  output logic [$clog2(RAM_WORDS)-1:0]    ram_idx_o,
  output pe_pkg::word_t                   ram_wdata_o,
  input  pe_pkg::word_t                   ram_rdata_i,
  output logic                            rom_en_o,
  output logic [$clog2(BOOT_WORDS)-1:0]   rom_idx_o,
  input  pe_pkg::word_t                   rom_rdata_i,
  output logic                            reg_sel_o,
  output logic                            reg_we_o,
  output logic [pe_pkg::REG_OFF_W-1:0]    reg_off_o,
  output pe_pkg::word_t                   reg_wdata_o,
  input  pe_pkg::word_t                   reg_rdata_i
);

  import pe_pkg::*;

  localparam int RAM_IW  = $clog2(RAM_WORDS);
  localparam int BOOT_IW = $clog2(BOOT_WORDS);

  typedef enum logic [1:0] {SRC_NONE, SRC_RAM, SRC_ROM, SRC_DMA} src_e;

  src_e                 src_n;
  src_e                 src_q;
  logic                 req;
  word_t                adr_al;
  word_t                word_idx;
  logic [REG_OFF_W-1:0] off;

  function automatic logic in_range(word_t adr, word_t base, word_t last);
    return (adr - base) <= (last - base);
  endfunction

  // new request only, the cycle being answered is still on the bus
  assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign adr_al   = {wb_adr_i[31:2], 2'b00};
  assign word_idx = wb_adr_i >> 2;
  assign off      = adr_al[REG_OFF_W-1:0];

  // region decode, SRC_NONE means err
  always_comb begin
    src_n = SRC_NONE;
    if (in_range(adr_al, RAM_BASE, RAM_LAST)) begin
      src_n = SRC_RAM;
    end else if (in_range(adr_al, BOOT_BASE, BOOT_LAST)) begin
      if (!wb_we_i) begin
        src_n = SRC_ROM;
      end
    end else if (in_range(adr_al, DMA_BASE, DMA_LAST)) begin
      if (off inside {REG_NODE_ID, REG_SEND_DEST, REG_SEND_ADDR, REG_SEND_SIZE,
                      REG_SEND_CMD, REG_STATUS, REG_RECV_ADDR, REG_RECV_PTR,
                      REG_RECV_SIZE, REG_RECV_CMD}) begin
        src_n = SRC_DMA;
      end
    end
  end

  // ========================================
  // target requests
  // ========================================
  assign ram_en_o    = req && (src_n == SRC_RAM);
  assign ram_we_o    = wb_we_i;
  assign ram_idx_o   = RAM_IW'(word_idx % RAM_WORDS);
  assign ram_wdata_o = wb_dat_i;

  assign rom_en_o  = req && (src_n == SRC_ROM);
  assign rom_idx_o = BOOT_IW'(word_idx % BOOT_WORDS);

  assign reg_sel_o   = req && (src_n == SRC_DMA);
  assign reg_we_o    = wb_we_i;
  assign reg_off_o   = off;
  assign reg_wdata_o = swap_bytes(wb_dat_i);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      src_q    <= SRC_NONE;
    end else begin
      wb_ack_o <= req && (src_n != SRC_NONE);
      wb_err_o <= req && (src_n == SRC_NONE);
      src_q    <= req ? src_n : SRC_NONE;
    end
  end

  // read data lines up with ack
  always_comb begin
    case (src_q)
      SRC_RAM: wb_dat_o = ram_rdata_i;
      SRC_ROM: wb_dat_o = rom_rdata_i;
      SRC_DMA: wb_dat_o = swap_bytes(reg_rdata_i);
      default: wb_dat_o = '0;
    endcase
  end

  a_ack_err_excl: assert property (@(posedge clock) disable iff (!reset)
    !(wb_ack_o && wb_err_o));

  a_answer_in_cycle: assert property (@(posedge clock) disable iff (!reset)
    (wb_ack_o || wb_err_o) |-> wb_cyc_i);

endmodule

// File: design/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int unsigned WORDS = 1024
) (
  input  logic                       clock,
  input  logic                       en_a_i,
  input  logic                       we_a_i,
  input  logic [$clog2(WORDS)-1:0]   idx_a_i,
  input  pe_pkg::word_t              wdata_a_i,
  output pe_pkg::word_t              rdata_a_o,
  input  logic                       en_b_i,
  input  logic                       we_b_i,
  input  logic [$clog2(WORDS)-1:0]   idx_b_i,
  input  pe_pkg::word_t              wdata_b_i,
  output pe_pkg::word_t              rdata_b_o
);

  import pe_pkg::*;

  word_t mem [WORDS];

  // read-first on both ports
  always_ff @(posedge clock) begin
    if (en_a_i) begin
      rdata_a_o <= mem[idx_a_i];
      if (we_a_i) begin
        mem[idx_a_i] <= wdata_a_i;
      end
    end
    if (en_b_i) begin
      rdata_b_o <= mem[idx_b_i];
      if (we_b_i) begin
        mem[idx_b_i] <= wdata_b_i;
      end
    end
  end

  // dma and processor must not write the same word together
  a_no_write_clash: assert property (@(posedge clock)
    !(en_a_i && we_a_i && en_b_i && we_b_i && (idx_a_i == idx_b_i)));

endmodule

// File: design/boot_rom.sv
`timescale 1ns/1ps

module boot_rom #(
  parameter int unsigned WORDS = 16
) (
  input  logic                       clock,
  input  logic                       en_i,
  input  logic [$clog2(WORDS)-1:0]   idx_i,
  output pe_pkg::word_t              rdata_o
);

  import pe_pkg::*;

  word_t mem [WORDS];

  initial begin
    $readmemh("design/boot_image.hex", mem);
  end

  always_ff @(posedge clock) begin
    if (en_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// File: design/dma_regs.sv
`timescale 1ns/1ps

module dma_regs #(
  parameter logic [15:0] NODE_ID = 16'h0000
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           sel_i,
  input  logic                           we_i,
  input  logic [pe_pkg::REG_OFF_W-1:0]   off_i,
  input  pe_pkg::word_t                  wdata_i,
  output pe_pkg::word_t                  rdata_o,
  output pe_pkg::dma_cfg_t               cfg_o,
  input  pe_pkg::dma_stat_t              stat_i
);

  import pe_pkg::*;

  word_t send_cmd_q;
  word_t recv_cmd_q;
  logic  wr;
  logic  rd;

  assign wr = sel_i && we_i;
  assign rd = sel_i && !we_i;

  // ========================================
  // writes and command pulses
  // ========================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      cfg_o      <= '0;
      send_cmd_q <= '0;
      recv_cmd_q <= '0;
    end else begin
      cfg_o.send_start <= 1'b0;
      cfg_o.recv_arm   <= 1'b0;
      if (wr) begin
        case (off_i)
          REG_SEND_DEST: cfg_o.send_dest <= wdata_i[15:0];
          REG_SEND_ADDR: cfg_o.send_addr <= wdata_i;
          REG_SEND_SIZE: cfg_o.send_size <= wdata_i[15:0];
          REG_SEND_CMD: begin
            send_cmd_q <= wdata_i;
            // a packet in flight keeps its config
            cfg_o.send_start <= (wdata_i != '0) && !stat_i.send_busy;
          end
          REG_RECV_ADDR: cfg_o.recv_addr <= wdata_i;
          REG_RECV_CMD: begin
            recv_cmd_q     <= wdata_i;
            cfg_o.recv_arm <= (wdata_i != '0);
          end
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // readback
  // ========================================
  always_ff @(posedge clock) begin
    if (rd) begin
      case (off_i)
        REG_NODE_ID:   rdata_o <= {16'h0, NODE_ID};
        REG_SEND_DEST: rdata_o <= {16'h0, cfg_o.send_dest};
        REG_SEND_ADDR: rdata_o <= cfg_o.send_addr;
        REG_SEND_SIZE: rdata_o <= {16'h0, cfg_o.send_size};
        REG_SEND_CMD:  rdata_o <= send_cmd_q;
        // send busy in the upper nibble, receive flags below
        REG_STATUS: begin
          rdata_o <= {27'h0, stat_i.send_busy, 2'b00, stat_i.recv_done, stat_i.recv_busy};
        end
        REG_RECV_ADDR: rdata_o <= cfg_o.recv_addr;
        REG_RECV_PTR:  rdata_o <= stat_i.recv_ptr;
        REG_RECV_SIZE: rdata_o <= {16'h0, stat_i.recv_size};
        REG_RECV_CMD:  rdata_o <= recv_cmd_q;
        default:       rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: design/dma_engine.sv
`timescale 1ns/1ps

module dma_engine #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic                            clock,
  input  logic                            reset,
  input  pe_pkg::dma_cfg_t                cfg_i,
  output pe_pkg::dma_stat_t               stat_o,
  output logic                            ram_en_o,
  output logic                            ram_we_o,
  output logic [$clog2(RAM_WORDS)-1:0]    ram_idx_o,
  output pe_pkg::word_t                   ram_wdata_o,
  input  pe_pkg::word_t                   ram_rdata_i,
  output pe_pkg::flit_t                   tx_flit_o,
  output logic                            tx_valid_o,
  input  logic                            tx_credit_i,
  input  pe_pkg::flit_t                   rx_flit_i,
  input  logic                            rx_valid_i,
  output logic                            rx_credit_o,
  output logic [1:0]                      irq_o
);

  import pe_pkg::*;

  localparam int RAM_IW = $clog2(RAM_WORDS);

  typedef enum logic [1:0] {S_IDLE, S_HDR, S_DATA} send_e;
  typedef enum logic [1:0] {R_IDLE, R_HDR, R_DATA} recv_e;

  send_e       sstate;
  recv_e       rstate;

  // send side
  word_t       rd_ptr;
  logic [15:0] rd_left;
  logic        rd_want;
  logic        rd_issue;
  logic        rd_pend;
  word_t       hold_q;
  logic        hold_v;
  logic        hold_v_n;
  flit_t       tx_q;
  logic        tx_v;
  logic        tx_fire;
  logic        tx_load;
  logic        send_end;
  logic        irq_send_q;

  // receive side
  word_t       rx_ptr;
  logic [15:0] rx_left;
  logic [15:0] rx_size;
  logic        rx_done;
  logic        rx_fire;
  logic        rx_wr;

  assign rx_credit_o = (rstate != R_IDLE);
  assign rx_fire     = rx_valid_i && rx_credit_o;
  assign rx_wr       = rx_fire && (rstate == R_DATA);

  assign tx_fire  = tx_v && tx_credit_i;
  assign tx_load  = !tx_v || tx_fire;
  // a word back from ram goes straight to tx if it is free, else into hold
  assign hold_v_n = rd_pend ? (hold_v || !tx_load) : (hold_v && !tx_load);
  // only read when the hold word is sure to be free for the answer
  assign rd_want  = (sstate != S_IDLE) && (rd_left != '0);
  assign rd_issue = rd_want && !hold_v_n && !rx_wr;
  assign send_end = (sstate == S_DATA) && (rd_left == '0) && !rd_pend && !hold_v && tx_load;

  // ========================================
  // ram port a, receive first
  // ========================================
  assign ram_en_o    = rx_wr || rd_issue;
  assign ram_we_o    = rx_wr;
  assign ram_idx_o   = rx_wr ? RAM_IW'(rx_ptr % RAM_WORDS) : RAM_IW'(rd_ptr % RAM_WORDS);
  assign ram_wdata_o = rx_flit_i.payload;

  // ========================================
  // send FSM
  // ========================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      sstate     <= S_IDLE;
      rd_ptr     <= '0;
      rd_left    <= '0;
      rd_pend    <= 1'b0;
      hold_v     <= 1'b0;
      tx_v       <= 1'b0;
      irq_send_q <= 1'b0;
    end else begin
      rd_pend    <= rd_issue;
      hold_v     <= hold_v_n;
      irq_send_q <= send_end;
      if (rd_issue) begin
        rd_ptr  <= rd_ptr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end
      case (sstate)
        S_IDLE: begin
          if (cfg_i.send_start) begin
            rd_ptr  <= cfg_i.send_addr;
            rd_left <= cfg_i.send_size;
            sstate  <= S_HDR;
          end
        end
        S_HDR: begin
          tx_v   <= 1'b1;
          sstate <= S_DATA;
        end
        S_DATA: begin
          if (tx_load) begin
            tx_v <= hold_v || rd_pend;
          end
          if (send_end) begin
            sstate <= S_IDLE;
          end
        end
        default: sstate <= S_IDLE;
      endcase
    end
  end

  // flit and hold words
  always_ff @(posedge clock) begin
    if (sstate == S_HDR) begin
      // rd_left still holds the full size here
      tx_q.header <= '{dest_x: cfg_i.send_dest[7:0], dest_y: cfg_i.send_dest[15:8],
                       size: rd_left};
    end else if (tx_load) begin
      tx_q.payload <= hold_v ? hold_q : ram_rdata_i;
    end
    if (rd_pend && (hold_v || !tx_load)) begin
      hold_q <= ram_rdata_i;
    end
  end

  // ========================================
  // receive FSM
  // ========================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      rstate  <= R_IDLE;
      rx_ptr  <= '0;
      rx_left <= '0;
      rx_size <= '0;
      rx_done <= 1'b0;
    end else begin
      case (rstate)
        R_IDLE: begin
          if (cfg_i.recv_arm) begin
            rx_ptr  <= cfg_i.recv_addr;
            rx_done <= 1'b0;
            rstate  <= R_HDR;
          end
        end
        R_HDR: begin
          if (rx_fire) begin
            rx_size <= rx_flit_i.header.size;
            rx_left <= rx_flit_i.header.size;
            if (rx_flit_i.header.size == '0) begin
              rx_done <= 1'b1;
              rstate  <= R_IDLE;
            end else begin
              rstate <= R_DATA;
            end
          end
        end
        R_DATA: begin
          if (rx_fire) begin
            rx_ptr  <= rx_ptr + 1'b1;
            rx_left <= rx_left - 1'b1;
            if (rx_left == 16'd1) begin
              rx_done <= 1'b1;
              rstate  <= R_IDLE;
            end
          end
        end
        default: rstate <= R_IDLE;
      endcase
    end
  end

  assign tx_flit_o  = tx_q;
  assign tx_valid_o = tx_v;
  assign irq_o      = {rx_done, irq_send_q};

  assign stat_o = '{send_busy: (sstate != S_IDLE), recv_busy: (rstate != R_IDLE),
                    recv_done: rx_done, recv_ptr: rx_ptr, recv_size: rx_size};

  // a held flit waits unchanged for credit
  a_tx_stable: assert property (@(posedge clock) disable iff (!reset)
    (tx_valid_o && !tx_credit_i) |=> (tx_valid_o && $stable(tx_flit_o)));

endmodule

// File: design/pe_node_top.sv
`timescale 1ns/1ps

module pe_node_top #(
  parameter int unsigned RAM_WORDS  = 1024,
  parameter int unsigned BOOT_WORDS = 16,
  parameter logic [15:0] NODE_ID    = 16'h0000
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  pe_pkg::word_t    wb_adr_i,
  input  pe_pkg::word_t    wb_dat_i,
  output pe_pkg::word_t    wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  output pe_pkg::flit_t    tx_flit_o,
  output logic             tx_valid_o,
  input  logic             credit_i,
  input  pe_pkg::flit_t    rx_flit_i,
  input  logic             rx_valid_i,
  output logic             credit_o,
  output logic [1:0]       irq_o
);

  import pe_pkg::*;

  localparam int RAM_IW  = $clog2(RAM_WORDS);
  localparam int BOOT_IW = $clog2(BOOT_WORDS);

  // ram port a belongs to the engine, port b to the bus
  logic                 ram_a_en;
  logic                 ram_a_we;
  logic [RAM_IW-1:0]    ram_a_idx;
  word_t                ram_a_wdata;
  word_t                ram_a_rdata;
  logic                 ram_b_en;
  logic                 ram_b_we;
  logic [RAM_IW-1:0]    ram_b_idx;
  word_t                ram_b_wdata;
  word_t                ram_b_rdata;

  logic                 rom_en;
  logic [BOOT_IW-1:0]   rom_idx;
  word_t                rom_rdata;

  logic                 reg_sel;
  logic                 reg_we;
  logic [REG_OFF_W-1:0] reg_off;
  word_t                reg_wdata;
  word_t                reg_rdata;

  dma_cfg_t             dma_cfg;
  dma_stat_t            dma_stat;

  pe_bus_decoder #(.RAM_WORDS(RAM_WORDS), .BOOT_WORDS(BOOT_WORDS)) u_decoder (
    .clock(clock), .reset(reset),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
    .ram_en_o(ram_b_en), .ram_we_o(ram_b_we), .ram_idx_o(ram_b_idx),
    .ram_wdata_o(ram_b_wdata), .ram_rdata_i(ram_b_rdata),
    .rom_en_o(rom_en), .rom_idx_o(rom_idx), .rom_rdata_i(rom_rdata),
    .reg_sel_o(reg_sel), .reg_we_o(reg_we), .reg_off_o(reg_off),
    .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
  );

  dual_port_ram #(.WORDS(RAM_WORDS)) u_ram (
    .clock(clock),
    .en_a_i(ram_a_en), .we_a_i(ram_a_we), .idx_a_i(ram_a_idx),
    .wdata_a_i(ram_a_wdata), .rdata_a_o(ram_a_rdata),
    .en_b_i(ram_b_en), .we_b_i(ram_b_we), .idx_b_i(ram_b_idx),
    .wdata_b_i(ram_b_wdata), .rdata_b_o(ram_b_rdata)
  );

  boot_rom #(.WORDS(BOOT_WORDS)) u_rom (
    .clock(clock), .en_i(rom_en), .idx_i(rom_idx), .rdata_o(rom_rdata)
  );

  dma_regs #(.NODE_ID(NODE_ID)) u_regs (
    .clock(clock), .reset(reset),
    .sel_i(reg_sel), .we_i(reg_we), .off_i(reg_off),
    .wdata_i(reg_wdata), .rdata_o(reg_rdata),
    .cfg_o(dma_cfg), .stat_i(dma_stat)
  );

  dma_engine #(.RAM_WORDS(RAM_WORDS)) u_engine (
    .clock(clock), .reset(reset),
    .cfg_i(dma_cfg), .stat_o(dma_stat),
    .ram_en_o(ram_a_en), .ram_we_o(ram_a_we), .ram_idx_o(ram_a_idx),
    .ram_wdata_o(ram_a_wdata), .ram_rdata_i(ram_a_rdata),
    .tx_flit_o(tx_flit_o), .tx_valid_o(tx_valid_o), .tx_credit_i(credit_i),
    .rx_flit_i(rx_flit_i), .rx_valid_i(rx_valid_i), .rx_credit_o(credit_o),
    .irq_o(irq_o)
  );

endmodule

// File: test/tb_pe_node.sv
`timescale 1ns/1ps

module tb_pe_node;

  import pe_pkg::*;

  localparam int unsigned RAM_WORDS    = 1024;
  localparam int unsigned BOOT_WORDS   = 16;
  localparam int          RESET_CYCLES = 8;
  localparam int          PKT_WORDS    = 8;
  localparam int          PKT_FLITS    = PKT_WORDS + 1;
  localparam word_t       SRC_BASE     = 32'h4000_0100;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT_IRQ, OP_STALL} op_e;

  typedef struct packed {
    op_e   op;
    word_t adr;
    word_t data;
    word_t exp_data;
    logic  want_err;
  } step_t;

  logic        clock;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  word_t       wb_adr;
  word_t       wb_dat_w;
  word_t       wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  flit_t       tx_flit;
  logic        tx_valid;
  logic        link_credit;
  flit_t       rx_flit;
  logic        rx_valid;
  logic        rx_credit;
  logic [1:0]  irq;

  step_t       steps[$];
  logic        table_ready;
  logic [31:0] lfsr;
  logic        go;
  logic        stall_on;
  logic        held;
  flit_t       held_flit;
  int          packet_count;
  int          send_irqs;

  pe_node_top #(
    .RAM_WORDS(RAM_WORDS), .BOOT_WORDS(BOOT_WORDS), .NODE_ID(16'h0201)
  ) DUT (
    .clock(clock), .reset(reset),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err),
    .tx_flit_o(tx_flit), .tx_valid_o(tx_valid), .credit_i(link_credit),
    .rx_flit_i(rx_flit), .rx_valid_i(rx_valid), .credit_o(rx_credit),
    .irq_o(irq)
  );

  always #5 clock = ~clock;

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic mismatch(input string name, input word_t exp, input word_t got);
    abort_run($sformatf("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got));
  endtask

  function automatic logic [31:0] step_lfsr(input logic [31:0] s);
    logic fb;
    // taps for x^32 + x^22 + x^2 + x + 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // source data, every address bit takes part
  function automatic word_t fill_word(input word_t adr);
    return {adr[15:0], adr[31:16]} ^ 32'h6b3c_a5d1;
  endfunction

  function automatic word_t dma_adr(input logic [REG_OFF_W-1:0] off);
    return DMA_BASE | word_t'(off);
  endfunction

  task automatic add_step(input op_e op, input word_t adr, input word_t data,
                          input word_t exp_data, input logic want_err);
    steps.push_back('{op, adr, data, exp_data, want_err});
  endtask

  // arm, send to ourselves, then check the landed words and counters
  task automatic add_packet(input word_t recv_cfg, input word_t ptr_exp,
                            input word_t dst_base, input logic stall);
    packet_count++;
    add_step(OP_STALL, '0, {31'h0, stall}, '0, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_RECV_ADDR), recv_cfg, '0, 1'b0);
    add_step(OP_READ, dma_adr(REG_RECV_ADDR), '0, recv_cfg, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_RECV_CMD), 32'h0100_0000, '0, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_SEND_CMD), 32'h0100_0000, '0, 1'b0);
    add_step(OP_WAIT_IRQ, '0, '0, '0, 1'b0);
    for (int i = 0; i < PKT_WORDS; i++) begin
      add_step(OP_READ, dst_base + word_t'(4 * i), '0,
               fill_word(SRC_BASE + word_t'(4 * i)), 1'b0);
    end
    add_step(OP_READ, dma_adr(REG_RECV_SIZE), '0, 32'h0800_0000, 1'b0);
    add_step(OP_READ, dma_adr(REG_RECV_PTR), '0, ptr_exp, 1'b0);
    // recv_done set, both busy flags clear
    add_step(OP_READ, dma_adr(REG_STATUS), '0, 32'h0200_0000, 1'b0);
  endtask

  task automatic build_table();
    // boot ROM words, wrap at 16 words, no writes
    add_step(OP_READ, 32'h0000_0000, '0, 32'h4000_02b7, 1'b0);
    add_step(OP_READ, 32'h0000_0004, '0, 32'h2000_0337, 1'b0);
    add_step(OP_READ, 32'h0000_002c, '0, 32'h2468_ace0, 1'b0);
    add_step(OP_READ, 32'h0000_003c, '0, 32'ha5a5_5a5a, 1'b0);
    add_step(OP_READ, 32'h0000_0040, '0, 32'h4000_02b7, 1'b0);
    add_step(OP_READ, 32'h0000_0048, '0, 32'h0003_2383, 1'b0);
    add_step(OP_READ, 32'h1fff_fffc, '0, 32'ha5a5_5a5a, 1'b0);
    add_step(OP_WRITE, 32'h0000_0010, 32'h1111_2222, '0, 1'b1);
    // RAM readback and aliasing one RAM size higher
    add_step(OP_WRITE, 32'h4000_0020, 32'hfeed_0001, '0, 1'b0);
    add_step(OP_READ, 32'h4000_0020, '0, 32'hfeed_0001, 1'b0);
    add_step(OP_READ, 32'h4000_1020, '0, 32'hfeed_0001, 1'b0);
    add_step(OP_WRITE, 32'h4000_2024, 32'h1234_abcd, '0, 1'b0);
    add_step(OP_READ, 32'h4000_0024, '0, 32'h1234_abcd, 1'b0);
    // DMA registers, big-endian view from the core
    add_step(OP_READ, dma_adr(REG_NODE_ID), '0, 32'h0102_0000, 1'b0);
    add_step(OP_READ, dma_adr(REG_STATUS), '0, 32'h0000_0000, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_SEND_DEST), 32'h0102_0000, '0, 1'b0);
    add_step(OP_READ, dma_adr(REG_SEND_DEST), '0, 32'h0102_0000, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_SEND_ADDR), 32'h4000_0000, '0, 1'b0);
    add_step(OP_READ, dma_adr(REG_SEND_ADDR), '0, 32'h4000_0000, 1'b0);
    add_step(OP_WRITE, dma_adr(REG_SEND_SIZE), 32'h0800_0000, '0, 1'b0);
    add_step(OP_READ, dma_adr(REG_SEND_SIZE), '0, 32'h0800_0000, 1'b0);
    // unmapped addresses
    add_step(OP_READ, 32'h2000_0028, '0, '0, 1'b1);
    add_step(OP_WRITE, 32'h2000_0040, 32'h0000_0001, '0, 1'b1);
    add_step(OP_READ, 32'h3000_0000, '0, '0, 1'b1);
    add_step(OP_WRITE, 32'h6000_0000, 32'h0000_0001, '0, 1'b1);
    add_step(OP_READ, 32'hffff_fffc, '0, '0, 1'b1);
    // packet source at RAM word 0x40
    for (int i = 0; i < PKT_WORDS; i++) begin
      add_step(OP_WRITE, SRC_BASE + word_t'(4 * i), fill_word(SRC_BASE + word_t'(4 * i)),
               '0, 1'b0);
    end
    add_step(OP_READ, dma_adr(REG_SEND_CMD), '0, 32'h0000_0000, 1'b0);
    add_packet(32'h0001_0000, 32'h0801_0000, 32'h4000_0400, 1'b0);
    add_packet(32'h8001_0000, 32'h8801_0000, 32'h4000_0600, 1'b1);
  endtask

  // ========================================
  // bus model
  // ========================================
  // called 1 ns after a rising edge, returns at the same phase
  task automatic bus_access(input logic we, input word_t adr, input word_t wdata,
                            output word_t rdata, output logic ack, output logic err);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge clock);
      #1;
    end while (!(wb_ack || wb_err));
    ack    = wb_ack;
    err    = wb_err;
    rdata  = wb_dat_r;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // cyc stays up until the answer pulse is gone
    @(posedge clock);
    #1;
    wb_cyc = 1'b0;
  endtask

  task automatic apply_step(input int n, input step_t s);
    word_t rdata;
    logic  ack;
    logic  err;
    case (s.op)
      OP_WRITE, OP_READ: begin
        bus_access(s.op == OP_WRITE, s.adr, s.data, rdata, ack, err);
        if (s.want_err) begin
          assert (err && !ack) else
            abort_run($sformatf("step %0d: access to %h was not refused with err", n, s.adr));
        end else begin
          assert (ack && !err) else
            abort_run($sformatf("step %0d: access to %h got no ack", n, s.adr));
          if (s.op == OP_READ) begin
            assert (rdata == s.exp_data) else mismatch("wb_dat_o", s.exp_data, rdata);
          end
        end
      end
      OP_WAIT_IRQ: begin
        while (irq[1] !== 1'b1) begin
          @(posedge clock);
          #1;
        end
      end
      OP_STALL: stall_on = s.data[0];
      default: abort_run($sformatf("step %0d: unknown table operation", n));
    endcase
  endtask

  // ========================================
  // flit loopback with random credit stalls
  // ========================================
  assign rx_flit     = (tx_valid === 1'b1) ? tx_flit : '0;
  assign rx_valid    = (tx_valid === 1'b1) && go;
  assign link_credit = (rx_credit === 1'b1) && go;

  always @(posedge clock) begin
    #1;
    if (held) begin
      assert (tx_valid && (tx_flit == held_flit)) else
        abort_run("tx flit changed or dropped while waiting for credit");
    end
    // send done interrupt, one clock per packet
    if (reset && (irq[0] === 1'b1)) begin
      send_irqs++;
    end
    if (stall_on) begin
      lfsr = step_lfsr(lfsr);
      go   = lfsr[0];
    end else begin
      go = 1'b1;
    end
    held      = reset && (tx_valid === 1'b1) && !((rx_credit === 1'b1) && go);
    held_flit = tx_flit;
  end

  // ========================================
  // main sequence and watchdog
  // ========================================
  initial begin
    clock        = 1'b0;
    reset        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    lfsr         = 32'hcef4_3b79;
    go           = 1'b0;
    stall_on     = 1'b0;
    held         = 1'b0;
    held_flit    = '0;
    packet_count = 0;
    send_irqs    = 0;
    table_ready  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;
    @(posedge clock);
    #1;
    foreach (steps[i]) begin
      apply_step(i, steps[i]);
    end
    assert (send_irqs == packet_count) else
      mismatch("irq_o[0] pulses", word_t'(packet_count), word_t'(send_irqs));
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = RESET_CYCLES + steps.size() * 20 + PKT_FLITS * 40;
    repeat (limit) @(posedge clock);
    abort_run($sformatf("timeout: table not finished after %0d clocks", limit));
  end

endmodule

// File: design/boot_image.hex
// boot image for the PE, one 32-bit word per line, word 0 first
400002b7
20000337
00032383
0072a023
00428293
00430313
fe0318e3
0000006f
00000013
00000013
13579bdf
2468ace0
0badc0de
c001d00d
5a5aa5a5
a5a55a5a

// File: filelist.f
design/pe_pkg.sv
design/pe_bus_decoder.sv
design/dual_port_ram.sv
design/boot_rom.sv
design/dma_regs.sv
design/dma_engine.sv
design/pe_node_top.sv
test/tb_pe_node.sv

// File: Makefile
# Verilator flow for the PE node, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_pe_node
RTL_TOP    ?= pe_node_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter design/%,$(shell cat $(FILELIST)))
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "sim: failure reported, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
